/* common/mux_pkg.sv */
// Shared constants and width types of the AXI4 write multiplexer.
// The top PORT_IDX_BITS of every ID must already hold the upstream port
// index, because B responses are routed on those bits.
// NUM_PORTS is assumed to be a power of two.

package mux_pkg;

  // ------------------------------
  // Sizes
  // ------------------------------
  localparam int unsigned NUM_PORTS     = 4;
  localparam int unsigned PORT_IDX_BITS = $clog2(NUM_PORTS);
  localparam int unsigned ID_WIDTH      = 6;
  localparam int unsigned ADDR_WIDTH    = 32;
  localparam int unsigned DATA_WIDTH    = 32;
  // Accepted AWs whose W data is still pending
  localparam int unsigned W_FIFO_DEPTH  = 4;

  // ------------------------------
  // Channel field types
  // ------------------------------
  typedef logic [PORT_IDX_BITS-1:0]  port_idx_t;
  typedef logic [ID_WIDTH-1:0]       axi_id_t;
  typedef logic [ADDR_WIDTH-1:0]     addr_t;
  // Burst length minus one
  typedef logic [7:0]                len_t;
  typedef logic [DATA_WIDTH-1:0]     data_t;
  typedef logic [DATA_WIDTH/8-1:0]   strb_t;
  typedef logic [1:0]                resp_t;

endpackage

/* common/aw_chan_if.sv */
// AW channel between the arbiter and the write steering.
// Carries only the fields this multiplexer forwards: id, addr and len.
// Valid and payload hold stable until the valid/ready handshake.

interface aw_chan_if;

  import mux_pkg::*;

  logic    valid;
  logic    ready;
  axi_id_t id;
  addr_t   addr;
  len_t    len;

  // Arbiter side
  modport src (
    output valid, id, addr, len,
    input  ready
  );

  // Steering side
  modport dst (
    input  valid, id, addr, len,
    output ready
  );

endinterface

/* hdl/aw_arbiter.sv */
// Round-robin AW arbiter with lock-in.
// A port that is offered and not yet accepted keeps the grant until its
// handshake, so the forwarded AW never changes while it waits.
// Upstream masters must keep aw_valid_i high until accepted.

module aw_arbiter (
  input  logic                                        clk_i,
  input  logic                                        rst_n_i,
  input  logic                [mux_pkg::NUM_PORTS-1:0] aw_valid_i,
  input  mux_pkg::axi_id_t    [mux_pkg::NUM_PORTS-1:0] aw_id_i,
  input  mux_pkg::addr_t      [mux_pkg::NUM_PORTS-1:0] aw_addr_i,
  input  mux_pkg::len_t       [mux_pkg::NUM_PORTS-1:0] aw_len_i,
  output logic                [mux_pkg::NUM_PORTS-1:0] aw_ready_o,
  aw_chan_if.src                                      aw
);

  import mux_pkg::*;

  port_idx_t prio_q;
  logic      lock_q;
  port_idx_t lock_idx_q;
  port_idx_t sel_idx;

  // ------------------------------
  // Port selection
  // ------------------------------
  always_comb begin : proc_select
    port_idx_t cand;
    logic      found;
    sel_idx = lock_q ? lock_idx_q : prio_q;
    found   = lock_q;
    // Search from the priority pointer upwards, wrapping around
    for (int unsigned i = 0; i < NUM_PORTS; i++) begin
      cand = port_idx_t'((prio_q + i) % NUM_PORTS);
      if (!found && aw_valid_i[cand]) begin
        sel_idx = cand;
        found   = 1'b1;
      end
    end
  end

  assign aw.valid = aw_valid_i[sel_idx];
  assign aw.id    = aw_id_i[sel_idx];
  assign aw.addr  = aw_addr_i[sel_idx];
  assign aw.len   = aw_len_i[sel_idx];

  always_comb begin : proc_ready
    aw_ready_o          = '0;
    aw_ready_o[sel_idx] = aw.valid & aw.ready;
  end

  // ------------------------------
  // Lock and priority state
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin : proc_state
    if (!rst_n_i) begin
      prio_q     <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else if (aw.valid && aw.ready) begin
      lock_q <= 1'b0;
      // Next round starts after the port just served
      prio_q <= port_idx_t'(sel_idx + 1'b1);
    end else if (aw.valid) begin
      lock_q     <= 1'b1;
      lock_idx_q <= sel_idx;
    end
  end

endmodule

/* write_steer/w_order_fifo.sv */
// Order FIFO of upstream port indices, W_FIFO_DEPTH entries deep.
// No fall-through: a pushed entry shows on data_o one cycle later.
// The caller must not push when full or pop when empty.

module w_order_fifo (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               push_i,
  input  logic               pop_i,
  input  mux_pkg::port_idx_t data_i,
  output mux_pkg::port_idx_t data_o,
  output logic               full_o,
  output logic               empty_o
);

  import mux_pkg::*;

  port_idx_t                           mem_q [W_FIFO_DEPTH];
  logic [$clog2(W_FIFO_DEPTH)-1:0]     wr_ptr_q;
  logic [$clog2(W_FIFO_DEPTH)-1:0]     rd_ptr_q;
  logic [$clog2(W_FIFO_DEPTH+1)-1:0]   count_q;

  assign data_o  = mem_q[rd_ptr_q];
  assign full_o  = (count_q == W_FIFO_DEPTH);
  assign empty_o = (count_q == '0);

  // Storage
  always_ff @(posedge clk_i) begin : proc_mem
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // ------------------------------
  // Pointers and fill level
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin : proc_ptr
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == W_FIFO_DEPTH - 1) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == W_FIFO_DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
      end
      // Push and pop together leave the level unchanged
      if (push_i && !pop_i) begin
        count_q <= count_q + 1'b1;
      end else if (pop_i && !push_i) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

/* write_steer/write_steer.sv */
// Write steering: forwards the granted AW and routes W beats in AW order.
// AW is held off while W_FIFO_DEPTH bursts wait for their data.
// W data of a burst can pass from the cycle after its AW is accepted.

module write_steer (
  input  logic                                         clk_i,
  input  logic                                         rst_n_i,
  aw_chan_if.dst                                       aw,
  output logic                                         m_aw_valid_o,
  input  logic                                         m_aw_ready_i,
  output mux_pkg::axi_id_t                             m_aw_id_o,
  output mux_pkg::addr_t                               m_aw_addr_o,
  output mux_pkg::len_t                                m_aw_len_o,
  input  logic                 [mux_pkg::NUM_PORTS-1:0] w_valid_i,
  input  mux_pkg::data_t       [mux_pkg::NUM_PORTS-1:0] w_data_i,
  input  mux_pkg::strb_t       [mux_pkg::NUM_PORTS-1:0] w_strb_i,
  input  logic                 [mux_pkg::NUM_PORTS-1:0] w_last_i,
  output logic                 [mux_pkg::NUM_PORTS-1:0] w_ready_o,
  output logic                                         m_w_valid_o,
  output mux_pkg::data_t                               m_w_data_o,
  output mux_pkg::strb_t                               m_w_strb_o,
  output logic                                         m_w_last_o,
  input  logic                                         m_w_ready_i
);

  import mux_pkg::*;

  logic      fifo_full;
  logic      fifo_empty;
  logic      fifo_push;
  logic      fifo_pop;
  port_idx_t head_idx;

  // ------------------------------
  // AW channel
  // ------------------------------
  assign m_aw_valid_o = aw.valid & ~fifo_full;
  assign aw.ready     = m_aw_ready_i & ~fifo_full;
  assign m_aw_id_o    = aw.id;
  assign m_aw_addr_o  = aw.addr;
  assign m_aw_len_o   = aw.len;
  assign fifo_push    = m_aw_valid_o & m_aw_ready_i;

  w_order_fifo i_w_order_fifo (
    .clk_i   ( clk_i                              ),
    .rst_n_i ( rst_n_i                            ),
    .push_i  ( fifo_push                          ),
    .pop_i   ( fifo_pop                           ),
    .data_i  ( aw.id[ID_WIDTH-1 -: PORT_IDX_BITS] ),
    .data_o  ( head_idx                           ),
    .full_o  ( fifo_full                          ),
    .empty_o ( fifo_empty                         )
  );

  // ------------------------------
  // W channel
  // ------------------------------
  assign m_w_data_o  = w_data_i[head_idx];
  assign m_w_strb_o  = w_strb_i[head_idx];
  assign m_w_last_o  = w_last_i[head_idx];
  assign m_w_valid_o = ~fifo_empty & w_valid_i[head_idx];

  always_comb begin : proc_w_ready
    w_ready_o           = '0;
    w_ready_o[head_idx] = ~fifo_empty & m_w_ready_i;
  end

  // Burst done on its last beat
  assign fifo_pop = m_w_valid_o & m_w_ready_i & m_w_last_o;

endmodule

/* hdl/b_router.sv */
// B response router.
// The port is taken from the top PORT_IDX_BITS of the response ID; that index
// is neither added nor checked here. ID and resp go to every port.

module b_router (
  input  logic                                      m_b_valid_i,
  input  mux_pkg::axi_id_t                          m_b_id_i,
  input  mux_pkg::resp_t                            m_b_resp_i,
  output logic                                      m_b_ready_o,
  output logic              [mux_pkg::NUM_PORTS-1:0] b_valid_o,
  output mux_pkg::axi_id_t                          b_id_o,
  output mux_pkg::resp_t                            b_resp_o,
  input  logic              [mux_pkg::NUM_PORTS-1:0] b_ready_i
);

  import mux_pkg::*;

  port_idx_t dst_idx;

  assign dst_idx = m_b_id_i[ID_WIDTH-1 -: PORT_IDX_BITS];

  // Broadcast payload
  assign b_id_o   = m_b_id_i;
  assign b_resp_o = m_b_resp_i;

  // Valid to the addressed port only
  always_comb begin : proc_b_valid
    b_valid_o          = '0;
    b_valid_o[dst_idx] = m_b_valid_i;
  end

  assign m_b_ready_o = b_ready_i[dst_idx];

endmodule

/* hdl/axi_write_mux.sv */
// AXI4 write multiplexer, NUM_PORTS upstream ports onto one downstream port.
// Write path only; no read channels and no user signals.
// Each master must place its port index in the top ID bits.
// At most W_FIFO_DEPTH AWs may wait for W data at any time.

module axi_write_mux (
  input  logic                                        clk_i,
  input  logic                                        rst_n_i,
  // Upstream AW
  input  logic                [mux_pkg::NUM_PORTS-1:0] aw_valid_i,
  output logic                [mux_pkg::NUM_PORTS-1:0] aw_ready_o,
  input  mux_pkg::axi_id_t    [mux_pkg::NUM_PORTS-1:0] aw_id_i,
  input  mux_pkg::addr_t      [mux_pkg::NUM_PORTS-1:0] aw_addr_i,
  input  mux_pkg::len_t       [mux_pkg::NUM_PORTS-1:0] aw_len_i,
  // Upstream W
  input  logic                [mux_pkg::NUM_PORTS-1:0] w_valid_i,
  output logic                [mux_pkg::NUM_PORTS-1:0] w_ready_o,
  input  mux_pkg::data_t      [mux_pkg::NUM_PORTS-1:0] w_data_i,
  input  mux_pkg::strb_t      [mux_pkg::NUM_PORTS-1:0] w_strb_i,
  input  logic                [mux_pkg::NUM_PORTS-1:0] w_last_i,
  // Upstream B
  output logic                [mux_pkg::NUM_PORTS-1:0] b_valid_o,
  input  logic                [mux_pkg::NUM_PORTS-1:0] b_ready_i,
  output mux_pkg::axi_id_t                            b_id_o,
  output mux_pkg::resp_t                              b_resp_o,
  // Downstream AW
  output logic                                        m_aw_valid_o,
  input  logic                                        m_aw_ready_i,
  output mux_pkg::axi_id_t                            m_aw_id_o,
  output mux_pkg::addr_t                              m_aw_addr_o,
  output mux_pkg::len_t                               m_aw_len_o,
  // Downstream W
  output logic                                        m_w_valid_o,
  input  logic                                        m_w_ready_i,
  output mux_pkg::data_t                              m_w_data_o,
  output mux_pkg::strb_t                              m_w_strb_o,
  output logic                                        m_w_last_o,
  // Downstream B
  input  logic                                        m_b_valid_i,
  output logic                                        m_b_ready_o,
  input  mux_pkg::axi_id_t                            m_b_id_i,
  input  mux_pkg::resp_t                              m_b_resp_i
);

  aw_chan_if aw_if ();

  // ------------------------------
  // Input side
  // ------------------------------
  aw_arbiter i_aw_arbiter (
    .clk_i      ( clk_i      ),
    .rst_n_i    ( rst_n_i    ),
    .aw_valid_i ( aw_valid_i ),
    .aw_id_i    ( aw_id_i    ),
    .aw_addr_i  ( aw_addr_i  ),
    .aw_len_i   ( aw_len_i   ),
    .aw_ready_o ( aw_ready_o ),
    .aw         ( aw_if.src  )
  );

  // ------------------------------
  // Write steering
  // ------------------------------
  write_steer i_write_steer (
    .clk_i        ( clk_i        ),
    .rst_n_i      ( rst_n_i      ),
    .aw           ( aw_if.dst    ),
    .m_aw_valid_o ( m_aw_valid_o ),
    .m_aw_ready_i ( m_aw_ready_i ),
    .m_aw_id_o    ( m_aw_id_o    ),
    .m_aw_addr_o  ( m_aw_addr_o  ),
    .m_aw_len_o   ( m_aw_len_o   ),
    .w_valid_i    ( w_valid_i    ),
    .w_data_i     ( w_data_i     ),
    .w_strb_i     ( w_strb_i     ),
    .w_last_i     ( w_last_i     ),
    .w_ready_o    ( w_ready_o    ),
    .m_w_valid_o  ( m_w_valid_o  ),
    .m_w_data_o   ( m_w_data_o   ),
    .m_w_strb_o   ( m_w_strb_o   ),
    .m_w_last_o   ( m_w_last_o   ),
    .m_w_ready_i  ( m_w_ready_i  )
  );

  // ------------------------------
  // Output side
  // ------------------------------
  b_router i_b_router (
    .m_b_valid_i ( m_b_valid_i ),
    .m_b_id_i    ( m_b_id_i    ),
    .m_b_resp_i  ( m_b_resp_i  ),
    .m_b_ready_o ( m_b_ready_o ),
    .b_valid_o   ( b_valid_o   ),
    .b_id_o      ( b_id_o      ),
    .b_resp_o    ( b_resp_o    ),
    .b_ready_i   ( b_ready_i   )
  );

endmodule

/* tests/axi_write_mux_assert.sv */
// Handshake assertions on the downstream side of the write multiplexer.
// The open-burst count assumes exactly one W last per accepted AW.

module axi_write_mux_assert (
  input logic                                    clk_i,
  input logic                                    rst_n_i,
  input logic                                    m_aw_valid_o,
  input logic                                    m_aw_ready_i,
  input mux_pkg::axi_id_t                        m_aw_id_o,
  input mux_pkg::addr_t                          m_aw_addr_o,
  input mux_pkg::len_t                           m_aw_len_o,
  input logic                                    m_w_valid_o,
  input logic                                    m_w_ready_i,
  input mux_pkg::data_t                          m_w_data_o,
  input mux_pkg::strb_t                          m_w_strb_o,
  input logic                                    m_w_last_o,
  input logic              [mux_pkg::NUM_PORTS-1:0] b_valid_o
);

  import mux_pkg::*;

  // Accepted AWs still waiting for their last W beat
  logic [3:0] open_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin : proc_open
    if (!rst_n_i) begin
      open_q <= '0;
    end else begin
      open_q <= open_q + 4'(m_aw_valid_o & m_aw_ready_i)
                       - 4'(m_w_valid_o & m_w_ready_i & m_w_last_o);
    end
  end

  a_aw_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    m_aw_valid_o && !m_aw_ready_i |=>
      m_aw_valid_o && $stable({m_aw_id_o, m_aw_addr_o, m_aw_len_o}))
    else $error("Downstream AW changed before its handshake");

  a_w_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    m_w_valid_o && !m_w_ready_i |=>
      m_w_valid_o && $stable({m_w_data_o, m_w_strb_o, m_w_last_o}))
    else $error("Downstream W changed before its handshake");

  a_w_needs_aw: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    m_w_valid_o |-> open_q != '0)
    else $error("W valid with no AW outstanding");

  a_fifo_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    open_q <= 4'(W_FIFO_DEPTH))
    else $error("More AWs outstanding than the order FIFO holds");

  a_b_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(b_valid_o))
    else $error("B valid raised on more than one port");

endmodule

bind axi_write_mux axi_write_mux_assert i_assert (.*);

/* tests/tb_axi_write_mux.sv */
// Testbench for the AXI4 write multiplexer.
// Each port issues NB bursts of 1 to 4 beats, its port index in the top ID bits.
// The slave model applies random ready and returns one B per burst in W order.

module tb_axi_write_mux;

  import mux_pkg::*;

  localparam int NB         = 6;
  localparam int CLK_PERIOD = 100;
  localparam int BEAT_W     = DATA_WIDTH + DATA_WIDTH / 8 + 1;

  logic                    clk_i;
  logic                    rst_n_i;
  logic    [NUM_PORTS-1:0] aw_valid_i, aw_ready_o, w_valid_i, w_ready_o, w_last_i;
  axi_id_t [NUM_PORTS-1:0] aw_id_i;
  addr_t   [NUM_PORTS-1:0] aw_addr_i;
  len_t    [NUM_PORTS-1:0] aw_len_i;
  data_t   [NUM_PORTS-1:0] w_data_i;
  strb_t   [NUM_PORTS-1:0] w_strb_i;
  logic    [NUM_PORTS-1:0] b_valid_o, b_ready_i;
  axi_id_t                 b_id_o, m_aw_id_o, m_b_id_i;
  resp_t                   b_resp_o, m_b_resp_i;
  logic                    m_aw_valid_o, m_aw_ready_i, m_w_valid_o, m_w_ready_i, m_w_last_o;
  logic                    m_b_valid_i, m_b_ready_o;
  addr_t                   m_aw_addr_o;
  len_t                    m_aw_len_o;
  data_t                   m_w_data_o;
  strb_t                   m_w_strb_o;

  // Burst contents per port
  addr_t   addr_mem [NUM_PORTS][NB];
  len_t    len_mem  [NUM_PORTS][NB];
  data_t   data_mem [NUM_PORTS][NB][4];
  strb_t   strb_mem [NUM_PORTS][NB][4];
  int      aw_next  [NUM_PORTS];
  int      w_burst  [NUM_PORTS];
  int      w_beat   [NUM_PORTS];
  int      aw_seen  [NUM_PORTS];
  int      aw_log   [$];
  axi_id_t pend_ids [$];
  axi_id_t done_ids [$];
  int      total_beats;
  int      w_count;
  int      w_done;
  int      b_count;
  int      limit_cycles;
  logic    w_hold;
  logic    aw_stalled;
  logic [63:0] held_aw;

  axi_write_mux i_dut (.*);

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic compare_values(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  function automatic axi_id_t burst_id(int port, int k);
    return axi_id_t'((port << (ID_WIDTH - PORT_IDX_BITS)) | k);
  endfunction

  // Expected n-th downstream W beat as {last, strb, data}, walking the AW order
  function automatic logic [BEAT_W-1:0] expected_beat(int n);
    int taken [NUM_PORTS];
    int left;
    int beats;
    int p;
    taken = '{default: 0};
    left  = n;
    foreach (aw_log[i]) begin
      p     = aw_log[i];
      beats = int'(len_mem[p][taken[p]]) + 1;
      if (left < beats) begin
        return {left == beats - 1, strb_mem[p][taken[p]][left], data_mem[p][taken[p]][left]};
      end
      left = left - beats;
      taken[p]++;
    end
    return 'x;
  endfunction

  // ------------------------------
  // Upstream masters
  // ------------------------------
  always @(posedge clk_i) begin : drive_upstream
    if (rst_n_i) begin
      for (int p = 0; p < NUM_PORTS; p++) begin
        // AW back to back, so all ports request until their last burst
        if (aw_valid_i[p] && aw_ready_o[p]) begin
          aw_next[p]++;
        end
        aw_valid_i[p] <= aw_next[p] < NB;
        if (aw_next[p] < NB) begin
          aw_id_i[p]   <= burst_id(p, aw_next[p]);
          aw_addr_i[p] <= addr_mem[p][aw_next[p]];
          aw_len_i[p]  <= len_mem[p][aw_next[p]];
        end
        if (w_valid_i[p] && w_ready_o[p]) begin
          if (w_beat[p] == int'(len_mem[p][w_burst[p]])) begin
            w_burst[p]++;
            w_beat[p] = 0;
          end else begin
            w_beat[p]++;
          end
        end
        w_valid_i[p] <= 1'b0;
        if (w_burst[p] < NB) begin
          // A beat once offered stays up until taken
          if ((w_valid_i[p] && !w_ready_o[p]) || (!w_hold && $urandom % 4 != 0)) begin
            w_valid_i[p] <= 1'b1;
          end
          w_data_i[p] <= data_mem[p][w_burst[p]][w_beat[p]];
          w_strb_i[p] <= strb_mem[p][w_burst[p]][w_beat[p]];
          w_last_i[p] <= w_beat[p] == int'(len_mem[p][w_burst[p]]);
        end
      end
    end
  end

  // ------------------------------
  // Downstream slave
  // ------------------------------
  always @(posedge clk_i) begin : slave_model
    logic [31:0] rnd;
    rnd = $urandom;
    m_aw_ready_i <= rnd[1:0] != 2'b00;
    m_w_ready_i  <= rnd[3:2] != 2'b00;
    b_ready_i    <= rnd[4 +: NUM_PORTS];
    if (rst_n_i) begin
      if (m_aw_valid_o && m_aw_ready_i) begin
        pend_ids.push_back(m_aw_id_o);
      end
      if (m_w_valid_o && m_w_ready_i && m_w_last_o) begin
        done_ids.push_back(pend_ids.pop_front());
      end
      if (!m_b_valid_i || m_b_ready_o) begin
        m_b_valid_i <= done_ids.size() > 0;
        if (done_ids.size() > 0) begin
          m_b_id_i   <= done_ids.pop_front();
          m_b_resp_i <= rnd[9:8];
        end
      end
    end
  end

  // ------------------------------
  // Checker
  // ------------------------------
  always @(posedge clk_i) begin : check_outputs
    int src;
    int dst;
    int open_bursts;
    int head;
    logic [NUM_PORTS-1:0] exp_ready;
    logic [BEAT_W-1:0] exp_beat;
    if (rst_n_i) begin
      // Order model as it stood before this edge
      open_bursts = aw_log.size() - w_done;
      head        = (open_bursts > 0) ? aw_log[w_done] : 0;
      exp_ready   = '0;
      if (open_bursts > 0) begin
        exp_ready[head] = m_w_ready_i;
      end
      compare_values("w_ready_o", 64'(w_ready_o), 64'(exp_ready));
      compare_values("m_w_valid_o", 64'(m_w_valid_o),
                     64'((open_bursts > 0) && w_valid_i[head]));
      if (open_bursts == W_FIFO_DEPTH) begin
        compare_values("m_aw_valid_o", 64'(m_aw_valid_o), 64'(0));
      end
      exp_ready = '0;
      if (m_aw_valid_o && m_aw_ready_i) begin
        src = int'(m_aw_id_o[ID_WIDTH-1 -: PORT_IDX_BITS]);
        exp_ready[src] = 1'b1;
        // All ports request continuously, so grants rotate
        compare_values("aw source port", 64'(src), 64'(aw_log.size() % NUM_PORTS));
        compare_values("m_aw_id_o", 64'(m_aw_id_o), 64'(burst_id(src, aw_seen[src])));
        compare_values("m_aw_addr_o", 64'(m_aw_addr_o), 64'(addr_mem[src][aw_seen[src]]));
        compare_values("m_aw_len_o", 64'(m_aw_len_o), 64'(len_mem[src][aw_seen[src]]));
        aw_log.push_back(src);
        aw_seen[src]++;
      end
      compare_values("aw_ready_o", 64'(aw_ready_o), 64'(exp_ready));
      if (aw_stalled) begin
        compare_values("m_aw_valid_o", 64'(m_aw_valid_o), 64'(1));
        compare_values("m_aw payload", 64'({m_aw_id_o, m_aw_addr_o, m_aw_len_o}), held_aw);
      end
      aw_stalled = m_aw_valid_o && !m_aw_ready_i;
      held_aw    = 64'({m_aw_id_o, m_aw_addr_o, m_aw_len_o});
      if (m_w_valid_o && m_w_ready_i) begin
        exp_beat = expected_beat(w_count);
        compare_values("m_w_data_o", 64'(m_w_data_o), 64'(exp_beat[DATA_WIDTH-1:0]));
        compare_values("m_w_strb_o", 64'(m_w_strb_o), 64'(exp_beat[BEAT_W-2:DATA_WIDTH]));
        compare_values("m_w_last_o", 64'(m_w_last_o), 64'(exp_beat[BEAT_W-1]));
        w_count++;
        if (m_w_last_o) begin
          w_done++;
        end
      end
      dst = int'(m_b_id_i[ID_WIDTH-1 -: PORT_IDX_BITS]);
      compare_values("b_valid_o", 64'(b_valid_o), 64'(m_b_valid_i) << dst);
      if (m_b_valid_i) begin
        compare_values("b_id_o", 64'(b_id_o), 64'(m_b_id_i));
        compare_values("b_resp_o", 64'(b_resp_o), 64'(m_b_resp_i));
        compare_values("m_b_ready_o", 64'(m_b_ready_o), 64'(b_ready_i[dst]));
        if (m_b_ready_o) begin
          b_count++;
        end
      end
    end
  end

  initial begin : watchdog
    wait (limit_cycles > 0);
    #(limit_cycles * CLK_PERIOD);
    abort_run($sformatf("Timeout: run did not finish within %0d cycles", limit_cycles));
  end

  initial begin : main
    void'($urandom(32'h5a01));
    clk_i        = 1'b0;
    rst_n_i      = 1'b0;
    aw_valid_i   = '0;
    aw_id_i      = '0;
    aw_addr_i    = '0;
    aw_len_i     = '0;
    w_valid_i    = '0;
    w_data_i     = '0;
    w_strb_i     = '0;
    w_last_i     = '0;
    b_ready_i    = '0;
    m_aw_ready_i = 1'b0;
    m_w_ready_i  = 1'b0;
    m_b_valid_i  = 1'b0;
    m_b_id_i     = '0;
    m_b_resp_i   = '0;
    w_hold       = 1'b1;
    aw_stalled   = 1'b0;
    foreach (len_mem[p, k]) begin
      len_mem[p][k]  = len_t'($urandom % 4);
      addr_mem[p][k] = $urandom;
      total_beats    = total_beats + int'(len_mem[p][k]) + 1;
      for (int b = 0; b < 4; b++) begin
        data_mem[p][k][b] = $urandom;
        strb_mem[p][k][b] = strb_t'($urandom);
      end
    end
    limit_cycles = 100 + 12 * (total_beats + NUM_PORTS * NB);
    repeat (10) @(posedge clk_i);
    rst_n_i <= 1'b1;
    // W idle, so the order FIFO fills and AW stalls
    repeat (40) @(negedge clk_i);
    compare_values("AWs accepted with W idle", 64'(aw_log.size()), 64'(W_FIFO_DEPTH));
    w_hold = 1'b0;
    wait (b_count == NUM_PORTS * NB);
    @(negedge clk_i);
    if (w_count == total_beats && aw_log.size() == NUM_PORTS * NB) begin
      $display("Done: no errors");
      $finish;
    end else begin
      abort_run("Run ended with AW or W transfers missing");
    end
  end

endmodule

/* files.f */
common/mux_pkg.sv
common/aw_chan_if.sv
hdl/aw_arbiter.sv
write_steer/w_order_fifo.sv
write_steer/write_steer.sv
hdl/b_router.sv
hdl/axi_write_mux.sv
tests/axi_write_mux_assert.sv
tests/tb_axi_write_mux.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator, then judge the log
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_axi_write_mux -Mdir obj_dir -f files.f
./obj_dir/Vtb_axi_write_mux > sim.log 2>&1 || true
cat sim.log
if grep -q "Done: no errors" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
